/* source/rv32_pkg.sv */
package rv32_pkg;

  typedef logic [31:0] word_t;     // data or address word
  typedef logic [4:0]  reg_addr_t; // register index

  // major opcodes of the kept RV32I subset
  typedef enum logic [6:0] {
    op_reg    = 7'b011_0011,
    op_imm    = 7'b001_0011,
    op_lui    = 7'b011_0111,
    op_auipc  = 7'b001_0111,
    op_jal    = 7'b110_1111,
    op_jalr   = 7'b110_0111,
    op_branch = 7'b110_0011,
    op_system = 7'b111_0011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_pass_b  // lui
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none,
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu,
    br_always  // jal and jalr
  } branch_e;

  typedef enum logic {
    res_alu,
    res_link  // pc+4 for jumps
  } result_sel_e;

  // funct3 of the ALU group
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 of the branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam word_t EBREAK_WORD = 32'h0010_0073;
  localparam word_t NOP_WORD    = 32'h0000_0013; // addi x0, x0, 0

endpackage

/* source/stage_links.sv */
`timescale 1ns/100ps

// fetched instruction, fetch to decode
interface fetch_link import rv32_pkg::*; ();
  logic  valid; // one pulse per instruction
  word_t pc;
  word_t instr;

  modport source (output valid, pc, instr);
  modport sink (input valid, pc, instr);
endinterface

// decoded operands and controls, decode to execute
interface decode_link import rv32_pkg::*; ();
  logic        valid;
  word_t       pc;
  word_t       rs1_data;
  word_t       rs2_data;
  word_t       imm;
  alu_op_e     alu_op;
  logic        operand_b_is_imm;
  branch_e     branch;
  result_sel_e result_sel;
  reg_addr_t   rd;
  logic        rd_we;
  logic        pc_relative_base; // pc instead of rs1 as base
  logic        is_ebreak;

  modport source (output valid, pc, rs1_data, rs2_data, imm, alu_op, operand_b_is_imm,
                  branch, result_sel, rd, rd_we, pc_relative_base, is_ebreak);
  modport sink (input valid, pc, rs1_data, rs2_data, imm, alu_op, operand_b_is_imm,
                branch, result_sel, rd, rd_we, pc_relative_base, is_ebreak);
endinterface

// retired instruction, seen by decode, fetch and the top level
interface commit_link import rv32_pkg::*; ();
  logic      valid;
  word_t     pc;
  reg_addr_t rd;
  logic      we;
  word_t     data;
  word_t     next_pc; // always set, sequential or not
  logic      halt;    // sticky once ebreak retires

  modport source (output valid, pc, rd, we, data, next_pc, halt);
  modport sink (input valid, pc, rd, we, data, next_pc, halt);
endinterface

/* source/register_file.sv */
`timescale 1ns/100ps

module register_file import rv32_pkg::*; (
  input  logic      clk,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      we,
  input  reg_addr_t rd,
  input  word_t     rd_data
);

  word_t regs [32];

  // index zero is never written
  always_ff @(posedge clk) begin
    if (we && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

  // asynchronous reads, x0 forced to zero
  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

/* source/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage import rv32_pkg::*; #(
  parameter word_t RESET_PC = 32'h8000_0000
) (
  input  logic      clk,
  input  logic      reset,
  output word_t     paddr,
  output logic      psel,
  output logic      penable,
  input  word_t     prdata,
  input  logic      pready,
  fetch_link.source fetch,
  commit_link.sink  commit
);

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access
  } fetch_state_e;

  fetch_state_e state;
  word_t        pc;
  word_t        instr;
  logic         instr_valid;
  logic         start_pending; // first fetch after reset
  logic         redirect;
  logic         apb_done;

  // a halt commit leaves the FSM idle for good
  assign redirect = commit.valid && !commit.halt;
  assign apb_done = (state == st_access) && pready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= st_idle;
      start_pending <= 1'b1;
      instr_valid   <= 1'b0;
    end else begin
      instr_valid <= apb_done;
      case (state)
        st_idle: begin
          if (start_pending || redirect) begin
            state         <= st_setup;
            start_pending <= 1'b0;
          end
        end
        st_setup: state <= st_access;
        st_access: begin
          if (pready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= RESET_PC;
      instr <= NOP_WORD;
    end else begin
      if (redirect) begin
        pc <= commit.next_pc; // setup starts on the same edge
      end
      if (apb_done) begin
        instr <= prdata;
      end
    end
  end

  assign psel    = (state != st_idle);
  assign penable = (state == st_access);
  assign paddr   = pc; // stable through setup and access

  assign fetch.valid = instr_valid;
  assign fetch.pc    = pc;
  assign fetch.instr = instr;

endmodule

/* source/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage import rv32_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  fetch_link.sink    fetch,
  decode_link.source decoded,
  commit_link.sink   commit
);

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  reg_addr_t   rd;
  word_t       imm_i;
  word_t       imm_u;
  word_t       imm_j;
  word_t       imm_b;
  word_t       rs1_data;
  word_t       rs2_data;
  alu_op_e     alu_funct;
  branch_e     branch_cond;
  word_t       imm;
  alu_op_e     alu_op;
  logic        operand_b_is_imm;
  branch_e     branch;
  result_sel_e result_sel;
  logic        writes_rd;
  logic        pc_relative_base;

  assign opcode = opcode_e'(fetch.instr[6:0]);
  assign funct3 = fetch.instr[14:12];
  assign funct7 = fetch.instr[31:25];
  assign rs1    = fetch.instr[19:15];
  assign rs2    = fetch.instr[24:20];
  assign rd     = fetch.instr[11:7];

  assign imm_i = {{20{fetch.instr[31]}}, fetch.instr[31:20]};
  assign imm_u = {fetch.instr[31:12], 12'h000};
  assign imm_j = {{12{fetch.instr[31]}}, fetch.instr[19:12], fetch.instr[20],
                  fetch.instr[30:21], 1'b0};
  assign imm_b = {{20{fetch.instr[31]}}, fetch.instr[7], fetch.instr[30:25],
                  fetch.instr[11:8], 1'b0};

  register_file u_register_file (
    .clk      (clk),
    .rs1_addr (rs1),
    .rs2_addr (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (commit.valid && commit.we),
    .rd       (commit.rd),
    .rd_data  (commit.data)
  );

  // shared by register and immediate forms
  always_comb begin
    case (funct3)
      F3_ADD_SUB: alu_funct = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
      F3_SLL:     alu_funct = alu_sll;
      F3_SLT:     alu_funct = alu_slt;
      F3_SLTU:    alu_funct = alu_sltu;
      F3_XOR:     alu_funct = alu_xor;
      F3_SRL_SRA: alu_funct = funct7[5] ? alu_sra : alu_srl; // imm[10] for srai
      F3_OR:      alu_funct = alu_or;
      default:    alu_funct = alu_and;
    endcase
  end

  always_comb begin
    case (funct3)
      F3_BEQ:  branch_cond = br_eq;
      F3_BNE:  branch_cond = br_ne;
      F3_BLT:  branch_cond = br_lt;
      F3_BGE:  branch_cond = br_ge;
      F3_BLTU: branch_cond = br_ltu;
      F3_BGEU: branch_cond = br_geu;
      default: branch_cond = br_none; // reserved encodings
    endcase
  end

  always_comb begin
    imm              = imm_i;
    alu_op           = alu_add;
    operand_b_is_imm = 1'b1;
    branch           = br_none;
    result_sel       = res_alu;
    writes_rd        = 1'b0;
    pc_relative_base = 1'b0;
    case (opcode)
      op_reg: begin
        alu_op           = alu_funct;
        operand_b_is_imm = 1'b0;
        writes_rd        = 1'b1;
      end
      op_imm: begin
        alu_op    = alu_funct;
        writes_rd = 1'b1;
      end
      op_lui: begin
        imm       = imm_u;
        alu_op    = alu_pass_b;
        writes_rd = 1'b1;
      end
      op_auipc: begin
        imm              = imm_u;
        pc_relative_base = 1'b1;
        writes_rd        = 1'b1;
      end
      op_jal: begin
        imm              = imm_j;
        pc_relative_base = 1'b1;
        branch           = br_always;
        result_sel       = res_link;
        writes_rd        = 1'b1;
      end
      op_jalr: begin
        branch     = br_always; // base is rs1
        result_sel = res_link;
        writes_rd  = 1'b1;
      end
      op_branch: begin
        imm              = imm_b;
        operand_b_is_imm = 1'b0;
        pc_relative_base = 1'b1;
        branch           = branch_cond;
      end
      default: ; // system and unknown opcodes fall through to pc+4
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      decoded.valid <= 1'b0;
    end else begin
      decoded.valid <= fetch.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch.valid) begin
      decoded.pc               <= fetch.pc;
      decoded.rs1_data         <= rs1_data;
      decoded.rs2_data         <= rs2_data;
      decoded.imm              <= imm;
      decoded.alu_op           <= alu_op;
      decoded.operand_b_is_imm <= operand_b_is_imm;
      decoded.branch           <= branch;
      decoded.result_sel       <= result_sel;
      decoded.rd               <= rd;
      decoded.rd_we            <= writes_rd && (rd != 5'd0); // x0 never retires a write
      decoded.pc_relative_base <= pc_relative_base;
      decoded.is_ebreak        <= (fetch.instr == EBREAK_WORD);
    end
  end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage import rv32_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  decode_link.sink   decoded,
  commit_link.source commit
);

  word_t operand_a;
  word_t operand_b;
  word_t alu_result;
  word_t target_sum;
  word_t target;
  word_t link;
  word_t pc_next;
  word_t wb_data;
  logic  taken;

  // auipc, jal and branches use the pc as base
  assign operand_a = decoded.pc_relative_base ? decoded.pc : decoded.rs1_data;
  assign operand_b = decoded.operand_b_is_imm ? decoded.imm : decoded.rs2_data;

  always_comb begin
    case (decoded.alu_op)
      alu_add:    alu_result = operand_a + operand_b;
      alu_sub:    alu_result = operand_a - operand_b;
      alu_xor:    alu_result = operand_a ^ operand_b;
      alu_or:     alu_result = operand_a | operand_b;
      alu_and:    alu_result = operand_a & operand_b;
      alu_sll:    alu_result = operand_a << operand_b[4:0];
      alu_srl:    alu_result = operand_a >> operand_b[4:0];
      alu_sra:    alu_result = word_t'($signed(operand_a) >>> operand_b[4:0]);
      alu_slt:    alu_result = {31'd0, $signed(operand_a) < $signed(operand_b)};
      alu_sltu:   alu_result = {31'd0, operand_a < operand_b};
      alu_pass_b: alu_result = operand_b;
      default:    alu_result = operand_a + operand_b;
    endcase
  end

  // branch conditions always compare rs1 with rs2
  always_comb begin
    case (decoded.branch)
      br_eq:     taken = (decoded.rs1_data == decoded.rs2_data);
      br_ne:     taken = (decoded.rs1_data != decoded.rs2_data);
      br_lt:     taken = ($signed(decoded.rs1_data) < $signed(decoded.rs2_data));
      br_ge:     taken = ($signed(decoded.rs1_data) >= $signed(decoded.rs2_data));
      br_ltu:    taken = (decoded.rs1_data < decoded.rs2_data);
      br_geu:    taken = (decoded.rs1_data >= decoded.rs2_data);
      br_always: taken = 1'b1;
      default:   taken = 1'b0; // br_none
    endcase
  end

  // bit 0 only matters for jalr, pc-relative targets are already even
  assign target_sum = operand_a + decoded.imm;
  assign target     = {target_sum[31:1], 1'b0};

  assign link    = decoded.pc + 32'd4;
  assign pc_next = taken ? target : link;
  assign wb_data = (decoded.result_sel == res_link) ? link : alu_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      commit.valid <= 1'b0;
      commit.we    <= 1'b0;
      commit.halt  <= 1'b0;
    end else begin
      commit.valid <= decoded.valid;
      if (decoded.valid) begin
        commit.we <= decoded.rd_we;
      end
      if (decoded.valid && decoded.is_ebreak) begin
        commit.halt <= 1'b1; // held until reset
      end
    end
  end

  always_ff @(posedge clk) begin
    if (decoded.valid) begin
      commit.pc      <= decoded.pc;
      commit.rd      <= decoded.rd;
      commit.data    <= wb_data;
      commit.next_pc <= pc_next;
    end
  end

endmodule

/* source/rv32_core.sv */
`timescale 1ns/100ps

module rv32_core import rv32_pkg::*; #(
  parameter word_t RESET_PC = 32'h8000_0000
) (
  input  logic      clk,
  input  logic      reset,

  // APB requester, read only
  output word_t     paddr,
  output logic      psel,
  output logic      penable,
  input  word_t     prdata,
  input  logic      pready,

  // retire port
  output logic      retire_valid,
  output word_t     retire_pc,
  output logic      retire_we,
  output reg_addr_t retire_rd,
  output word_t     retire_data,
  output logic      halted
);

  fetch_link  u_fetch_link ();
  decode_link u_decode_link ();
  commit_link u_commit_link ();

  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) u_fetch_stage (
    .clk     (clk),
    .reset   (reset),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .prdata  (prdata),
    .pready  (pready),
    .fetch   (u_fetch_link.source),
    .commit  (u_commit_link.sink)
  );

  decode_stage u_decode_stage (
    .clk     (clk),
    .reset   (reset),
    .fetch   (u_fetch_link.sink),
    .decoded (u_decode_link.source),
    .commit  (u_commit_link.sink)
  );

  execute_stage u_execute_stage (
    .clk     (clk),
    .reset   (reset),
    .decoded (u_decode_link.sink),
    .commit  (u_commit_link.source)
  );

  assign retire_valid = u_commit_link.valid;
  assign retire_pc    = u_commit_link.pc;
  assign retire_we    = u_commit_link.we;
  assign retire_rd    = u_commit_link.rd;
  assign retire_data  = u_commit_link.data;
  assign halted       = u_commit_link.halt; // sticky in execute

endmodule

/* tb/core_tests.svh */
word_t imem [MEM_WORDS];
int    prog_len;
word_t model_regs [32];
word_t model_pc;
logic  model_halted;

task automatic check_word(input word_t got, input word_t exp, input string what);
  if (got !== exp) begin
    $display("[FAIL] t=%0t %s is %h, expected %h", $time, what, got, exp);
    stop_with_failure();
  end
endtask

task automatic check_reg(input reg_addr_t got, input reg_addr_t exp, input string what);
  if (got !== exp) begin
    $display("[FAIL] t=%0t %s is x%0d, expected x%0d", $time, what, got, exp);
    stop_with_failure();
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("[FAIL] t=%0t %s is %b, expected %b", $time, what, got, exp);
    stop_with_failure();
  end
endtask

// instruction encoders
function automatic word_t rtype(input logic [6:0] f7, input reg_addr_t rs2,
                                input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
  return {f7, rs2, rs1, f3, rd, 7'b011_0011};
endfunction

function automatic word_t itype(input logic [11:0] imm, input reg_addr_t rs1,
                                input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t utype(input logic [19:0] imm, input reg_addr_t rd,
                                input logic [6:0] op);
  return {imm, rd, op};
endfunction

function automatic word_t btype(input logic [12:0] off, input reg_addr_t rs2,
                                input reg_addr_t rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b110_0011};
endfunction

function automatic word_t jtype(input logic [20:0] off, input reg_addr_t rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, 7'b110_1111};
endfunction

function automatic word_t imem_word(input word_t addr);
  word_t idx;
  idx = (addr - RESET_PC) >> 2;
  if (idx < MEM_WORDS) begin
    return imem[idx];
  end
  return ~addr;
endfunction

task automatic clear_program();
  for (int i = 0; i < MEM_WORDS; i++) begin
    imem[i] = ~(RESET_PC + word_t'(i * 4)); // inverted address as filler
  end
  prog_len = 0;
endtask

task automatic emit(input word_t instr);
  imem[prog_len] = instr;
  prog_len++;
endtask

task automatic load_imm(input reg_addr_t rd, input word_t value);
  word_t upper;
  upper = value + 32'h800; // addi sign-extends the low part
  emit(utype(upper[31:12], rd, op_lui));
  emit(itype(value[11:0], rd, 3'b000, rd, op_imm));
endtask

task automatic clear_model();
  for (int i = 0; i < 32; i++) begin
    model_regs[i] = '0;
  end
  model_pc     = RESET_PC;
  model_halted = 1'b0;
endtask

// RV32I integer ops by funct3 where alt selects sub and sra
function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
  word_t r;
  case (f3)
    3'b000: r = alt ? a - b : a + b;
    3'b001: r = a << b[4:0];
    3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011: r = (a < b) ? 32'd1 : 32'd0;
    3'b100: r = a ^ b;
    3'b101: begin
      if (alt) begin
        r = $signed(a) >>> b[4:0];
      end else begin
        r = a >> b[4:0];
      end
    end
    3'b110: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
  case (f3)
    3'b000: return a == b;
    3'b001: return a != b;
    3'b100: return $signed(a) < $signed(b);
    3'b101: return $signed(a) >= $signed(b);
    3'b110: return a < b;
    3'b111: return a >= b;
    default: return 1'b0;
  endcase
endfunction

task automatic model_step(output logic we, output reg_addr_t rd, output word_t data,
                          output word_t next_pc, output logic halt);
  word_t ins;
  word_t a;
  word_t b;
  word_t imm_i;
  word_t imm_b;
  word_t imm_j;
  ins     = imem_word(model_pc);
  a       = model_regs[ins[19:15]];
  b       = model_regs[ins[24:20]];
  imm_i   = {{20{ins[31]}}, ins[31:20]};
  imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
  imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
  rd      = ins[11:7];
  we      = 1'b1;
  data    = '0;
  next_pc = model_pc + 32'd4;
  halt    = (ins == EBREAK_WORD);
  case (ins[6:0])
    op_reg:   data = ref_alu(ins[14:12], ins[30], a, b);
    op_imm:   data = ref_alu(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
    op_lui:   data = {ins[31:12], 12'h000};
    op_auipc: data = model_pc + {ins[31:12], 12'h000};
    op_jal: begin
      data    = model_pc + 32'd4;
      next_pc = model_pc + imm_j;
    end
    op_jalr: begin
      data    = model_pc + 32'd4;
      next_pc = (a + imm_i) & ~32'd1;
    end
    op_branch: begin
      we = 1'b0;
      if (branch_taken(ins[14:12], a, b)) begin
        next_pc = model_pc + imm_b;
      end
    end
    default: we = 1'b0; // system and unknown opcodes
  endcase
  if (rd == 5'd0) begin
    we = 1'b0;
  end
endtask

task automatic compare_retire();
  logic      exp_we;
  reg_addr_t exp_rd;
  word_t     exp_data;
  word_t     exp_next;
  logic      exp_halt;
  model_step(exp_we, exp_rd, exp_data, exp_next, exp_halt);
  check_word(retire_pc, model_pc, "retire_pc");
  check_flag(retire_we, exp_we, "retire_we");
  if (exp_we) begin
    check_reg(retire_rd, exp_rd, "retire_rd");
    check_word(retire_data, exp_data, "retire_data");
    model_regs[exp_rd] = exp_data;
  end
  check_flag(halted, exp_halt, "halted at retire");
  model_halted = exp_halt;
  model_pc     = exp_next;
endtask

task automatic execute_program(input logic waits);
  total_instr += prog_len;
  random_waits = waits;
  @(posedge clk);
  reset <= 1'b1;
  clear_model();
  repeat (2) @(posedge clk);
  reset <= 1'b0;
  do begin
    @(posedge clk);
  end while (!halted);
  // core must stay quiet once halted
  repeat (20) begin
    @(posedge clk);
    check_flag(psel, 1'b0, "psel after halt");
    check_flag(halted, 1'b1, "halted held");
  end
  check_flag(model_halted, 1'b1, "reference model reached ebreak");
endtask

task automatic alu_group(input logic waits);
  clear_program();
  load_imm(5'd1, 32'h8765_4321); // negative
  load_imm(5'd2, 32'h0000_1235);
  emit(itype(12'hffb, 5'd0, 3'b000, 5'd3, op_imm)); // x3 = -5
  for (int f = 0; f < 8; f++) begin
    emit(rtype(7'h00, 5'd2, 5'd1, f[2:0], reg_addr_t'(4 + f)));
  end
  emit(rtype(7'h20, 5'd2, 5'd1, 3'b000, 5'd12)); // sub
  emit(rtype(7'h20, 5'd2, 5'd1, 3'b101, 5'd13)); // sra of a negative value
  emit(rtype(7'h00, 5'd3, 5'd2, 3'b010, 5'd14)); // slt with mixed signs
  emit(rtype(7'h00, 5'd2, 5'd3, 3'b010, 5'd15));
  emit(rtype(7'h00, 5'd2, 5'd3, 3'b011, 5'd16)); // sltu with mixed signs
  emit(rtype(7'h00, 5'd3, 5'd2, 3'b011, 5'd17));
  for (int f = 0; f < 8; f++) begin
    emit(itype((f == 1 || f == 5) ? 12'(3 * f) : 12'hf9c, 5'd1, f[2:0],
               reg_addr_t'(18 + f), op_imm));
  end
  emit(itype({7'h20, 5'd9}, 5'd1, 3'b101, 5'd26, op_imm)); // srai
  emit(itype(12'd3, 5'd3, 3'b010, 5'd27, op_imm));
  emit(itype(12'hfff, 5'd3, 3'b011, 5'd28, op_imm));
  emit(EBREAK_WORD);
  execute_program(waits);
endtask

task automatic upper_immediates(input logic waits);
  clear_program();
  emit(utype(20'habcde, 5'd5, op_lui));
  emit(utype(20'h12345, 5'd6, op_auipc));
  emit(utype(20'hfffff, 5'd7, op_lui));
  emit(utype(20'h80000, 5'd8, op_auipc)); // wraps past the top
  emit(EBREAK_WORD);
  execute_program(waits);
endtask

task automatic branch_pairs(input logic waits);
  int f3s [6]   = '{0, 1, 4, 5, 6, 7};
  int t_rs1 [6] = '{2, 1, 1, 2, 2, 1};
  int t_rs2 [6] = '{3, 2, 2, 1, 1, 2};
  int n_rs1 [6] = '{1, 2, 2, 1, 1, 2};
  int n_rs2 [6] = '{2, 3, 1, 2, 2, 1};
  clear_program();
  emit(itype(12'hffd, 5'd0, 3'b000, 5'd1, op_imm)); // x1 = -3
  emit(itype(12'd5, 5'd0, 3'b000, 5'd2, op_imm));
  emit(itype(12'd5, 5'd0, 3'b000, 5'd3, op_imm));
  emit(itype(12'd0, 5'd0, 3'b000, 5'd10, op_imm)); // x10 counts fall-throughs
  for (int i = 0; i < 6; i++) begin
    emit(btype(13'd8, 5'(t_rs2[i]), 5'(t_rs1[i]), 3'(f3s[i]))); // taken branch skips the addi
    emit(itype(12'd1, 5'd10, 3'b000, 5'd10, op_imm));
    emit(btype(13'd8, 5'(n_rs2[i]), 5'(n_rs1[i]), 3'(f3s[i]))); // falls through
    emit(itype(12'd1, 5'd10, 3'b000, 5'd10, op_imm));
  end
  emit(itype(12'd3, 5'd0, 3'b000, 5'd4, op_imm)); // backward loop of three passes
  emit(itype(12'hfff, 5'd4, 3'b000, 5'd4, op_imm));
  emit(btype(13'h1ffc, 5'd0, 5'd4, 3'b001));
  emit(EBREAK_WORD);
  execute_program(waits);
endtask

task automatic jumps_and_x0();
  clear_program();
  emit(itype(12'd7, 5'd0, 3'b000, 5'd1, op_imm));
  emit(jtype(21'd8, 5'd2));
  emit(itype(12'd99, 5'd0, 3'b000, 5'd1, op_imm)); // skipped
  emit(utype(20'h00000, 5'd3, op_auipc));
  emit(itype(12'd13, 5'd3, 3'b000, 5'd4, op_jalr)); // odd target with bit 0 dropped
  emit(itype(12'd55, 5'd0, 3'b000, 5'd1, op_imm)); // skipped
  emit(itype(12'd5, 5'd1, 3'b000, 5'd0, op_imm)); // write to x0
  emit(rtype(7'h00, 5'd1, 5'd0, 3'b110, 5'd5)); // x0 reads as zero
  emit(jtype(21'd8, 5'd0));
  emit(itype(12'd1, 5'd0, 3'b000, 5'd1, op_imm));
  emit(EBREAK_WORD);
  execute_program(1'b0);
endtask

task automatic halt_only();
  clear_program();
  emit(EBREAK_WORD);
  execute_program(1'b0);
endtask

/* tb/tb_rv32_core.sv */
`timescale 1ns/100ps

module tb_rv32_core import rv32_pkg::*; ();

  localparam word_t       RESET_PC  = 32'h8000_0000;
  localparam int          MEM_WORDS = 64;
  localparam logic [31:0] SEED      = 32'hd10f_21af;

  logic      clk = 1'b0;
  logic      reset;
  word_t     paddr;
  logic      psel;
  logic      penable;
  word_t     prdata;
  logic      pready;
  logic      retire_valid;
  word_t     retire_pc;
  logic      retire_we;
  reg_addr_t retire_rd;
  word_t     retire_data;
  logic      halted;

  logic  random_waits  = 1'b0; // wait states on or off for the running program
  int    total_instr   = 0;    // grows with every program loaded
  int    cycle         = 0;
  int    edge_count    = 0;
  int    done_edge     = 0;    // edge of the last APB completion
  int    error_count   = 0;
  logic  prev_psel     = 1'b0;
  logic  prev_penable  = 1'b0;
  logic  prev_pready   = 1'b0;
  word_t prev_paddr    = '0;
  logic  psel_expected = 1'b0;

  `include "core_tests.svh"

  rv32_core u_dut (
    .clk          (clk),
    .reset        (reset),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .prdata       (prdata),
    .pready       (pready),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_we    (retire_we),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted)
  );

  always #4 clk = ~clk;

  task automatic stop_with_failure();
    error_count++;
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  // APB completer serving instruction memory with optional wait states
  initial begin : apb_completer
    int waits_left;
    void'($urandom(SEED));
    waits_left = 0;
    forever begin
      @(posedge clk);
      if (reset) begin
        pready <= 1'b0;
      end else if (psel && !penable) begin
        waits_left = random_waits ? $urandom_range(3, 0) : 0;
        pready <= (waits_left == 0);
        prdata <= imem_word(paddr);
      end else if (psel && penable) begin
        if (pready) begin
          pready <= 1'b0; // transfer completes on this edge
        end else begin
          waits_left--;
          pready <= (waits_left == 0);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle > total_instr * 20 + 100) begin
      $display("timeout after %0d cycles, the core stopped retiring", cycle);
      stop_with_failure();
    end
  end

  // bus protocol and retire monitor
  always @(posedge clk) begin
    edge_count++;
    if (reset) begin
      prev_psel     = 1'b0;
      psel_expected = 1'b0;
    end else begin
      if (prev_psel && !(prev_penable && prev_pready)) begin
        check_flag(psel, 1'b1, "psel held during transfer");
        check_flag(penable, 1'b1, "penable in access phase");
        check_word(paddr, prev_paddr, "paddr held during transfer");
      end
      if (psel_expected) begin
        check_flag(psel, 1'b1, "psel one cycle after retire");
      end
      psel_expected = 1'b0;
      if (psel && !penable) begin
        check_word(paddr, model_pc, "paddr in setup phase");
      end
      if (psel && penable && pready) begin
        done_edge = edge_count;
      end
      if (retire_valid) begin
        // rises two edges after completion and is sampled one edge later
        check_flag(edge_count == done_edge + 3, 1'b1, "retire two cycles after completion");
        compare_retire();
        psel_expected = !halted;
      end
      prev_psel    = psel;
      prev_penable = penable;
      prev_pready  = pready;
      prev_paddr   = paddr;
    end
  end

  initial begin
    reset  = 1'b1;
    prdata = '0;
    pready = 1'b0;
    alu_group(1'b0);
    upper_immediates(1'b0);
    branch_pairs(1'b0);
    jumps_and_x0();
    halt_only();
    alu_group(1'b1); // same programs with random wait states
    upper_immediates(1'b1);
    branch_pairs(1'b1);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* rv32_core.f */
+incdir+tb
source/rv32_pkg.sv
source/stage_links.sv
source/register_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/rv32_core.sv
tb/tb_rv32_core.sv
